//--- filelist.f
verilog/gmii_rx_pkg.sv
verilog/gmii_rx_writer.sv
verilog/gmii_rx_fifo.sv
verilog/gmii_frame_reader.sv
verilog/gmii_rx_top.sv
test/tb_gmii_rx.sv

//--- run_sim.sh
#!/bin/sh
# build and run the gmii receive buffer testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_gmii_rx \
    -f filelist.f \
    -o sim_gmii_rx

# the log decides pass or fail
./obj_dir/sim_gmii_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- test/tb_gmii_rx.sv
////////////////////
// testbench for the gmii receive buffer
// frame driver, reference model, output compare and watchdog
////////////////////

module tb_gmii_rx;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk_gmii_rx = 1'b0;
    logic        reset_n;
    logic        i_gmii_dv;
    logic [7:0]  iv_gmii_rxd;
    logic        i_gmii_er;
    logic        i_rd_en;
    logic        o_gmii_er;
    logic        o_fifo_overflow_pulse;
    logic [7:0]  o_rx_data;
    logic        o_rx_valid;
    logic        o_rx_sof;
    logic        o_rx_eof;
    logic        o_rx_trunc;
    logic [15:0] ov_good_frames;
    logic [15:0] ov_trunc_frames;

    integer      seed = 32'hbd89_98ac;
    int          lens_a [10] = '{2, 3, 7, 16, 17, 33, 60, 9, 2, 48};
    int          lens_b [4]  = '{2, 60, 25, 14};

    logic [7:0]  frame_q [$];   // bytes of the frame being sent
    logic [9:0]  exp_q [$];     // {sof, eof, data}
    logic [10:0] got_q [$];     // {sof, eof, trunc, data} under back-pressure
    int          exp_frames = 0;
    bit          trunc_phase = 1'b0;
    bit          ovf_seen = 1'b0;
    int          trunc_eofs = 0;
    int          er_seen = 0;

    gmii_rx_top #(
        .FIFO_DEPTH (16),
        .CNT_W      (16)
    ) gmii_rx_top_i (
        .clk_gmii_rx           (clk_gmii_rx),
        .reset_n               (reset_n),
        .i_gmii_dv             (i_gmii_dv),
        .iv_gmii_rxd           (iv_gmii_rxd),
        .i_gmii_er             (i_gmii_er),
        .i_rd_en               (i_rd_en),
        .o_gmii_er             (o_gmii_er),
        .o_fifo_overflow_pulse (o_fifo_overflow_pulse),
        .o_rx_data             (o_rx_data),
        .o_rx_valid            (o_rx_valid),
        .o_rx_sof              (o_rx_sof),
        .o_rx_eof              (o_rx_eof),
        .o_rx_trunc            (o_rx_trunc),
        .ov_good_frames        (ov_good_frames),
        .ov_trunc_frames       (ov_trunc_frames)
    );

    always #10 clk_gmii_rx = ~clk_gmii_rx;     // 20 ns period

    task automatic show_mismatch(input string sig, input int got, input int want);
        $display("Fail at %0t ns: %s is %0h, expected %0h", $time, sig, got, want);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////

    task automatic make_frame(input int len);
        int rnd;
        frame_q.delete();
        for (int i = 0; i < len; i++) begin
            rnd = $random(seed);
            frame_q.push_back(rnd[7:0]);
        end
    endtask

    // one byte per cycle, then 12 idle cycles
    task automatic drive_frame();
        int rnd;
        foreach (frame_q[i]) begin
            @(posedge clk_gmii_rx);
            #1;
            rnd         = $random(seed);
            i_gmii_dv   = 1'b1;
            iv_gmii_rxd = frame_q[i];
            i_gmii_er   = (rnd[2:0] == 3'd0);  // er now and then
        end
        @(posedge clk_gmii_rx);
        #1;
        i_gmii_dv   = 1'b0;
        iv_gmii_rxd = 8'h00;
        i_gmii_er   = 1'b0;
        repeat (11) @(posedge clk_gmii_rx);
    endtask

    // expected output: head byte carries sof, tail byte eof
    function automatic void model_frame(input logic [7:0] bytes_in [$]);
        int n;
        n = bytes_in.size();
        for (int i = 0; i < n; i++) begin
            exp_q.push_back({i == 0, i == n - 1, bytes_in[i]});
        end
        exp_frames++;
    endfunction

    function automatic bit is_subsequence(input logic [7:0] part [$],
                                          input logic [7:0] whole [$]);
        int j;
        j = 0;
        foreach (whole[k]) begin
            if (j < part.size() && whole[k] == part[j]) begin
                j++;
            end
        end
        return (j == part.size());
    endfunction

    // frame bytes plus gap, with slack for reset, back-pressure and drain
    function automatic int run_cycles();
        int total;
        total = 10 + 40 + 13 + 60;
        foreach (lens_a[i]) total += lens_a[i] + 13;
        foreach (lens_b[i]) total += lens_b[i] + 13;
        return total;
    endfunction

    ////////////////////
    // output compare
    ////////////////////

    always @(negedge clk_gmii_rx) begin : compare_out
        logic [9:0] exp_word;
        if (reset_n) begin
            assert (o_gmii_er == i_gmii_er)
                else show_mismatch("o_gmii_er", int'(o_gmii_er), int'(i_gmii_er));
            if (i_gmii_er) er_seen++;
            if (trunc_phase) begin
                if (o_fifo_overflow_pulse) ovf_seen = 1'b1;
                if (o_rx_valid) begin
                    got_q.push_back({o_rx_sof, o_rx_eof, o_rx_trunc, o_rx_data});
                    if (o_rx_eof) trunc_eofs++;
                end
            end else begin
                assert (!o_fifo_overflow_pulse)
                    else show_mismatch("o_fifo_overflow_pulse", 1, 0);
                if (o_rx_valid) begin
                    assert (exp_q.size() != 0)
                        else abort_run("a byte came out while no byte was expected");
                    exp_word = exp_q.pop_front();
                    assert (o_rx_data == exp_word[7:0])
                        else show_mismatch("o_rx_data", int'(o_rx_data), int'(exp_word[7:0]));
                    assert (o_rx_sof == exp_word[9])
                        else show_mismatch("o_rx_sof", int'(o_rx_sof), int'(exp_word[9]));
                    assert (o_rx_eof == exp_word[8])
                        else show_mismatch("o_rx_eof", int'(o_rx_eof), int'(exp_word[8]));
                    assert (!o_rx_trunc)
                        else show_mismatch("o_rx_trunc", 1, 0);
                end
            end
        end
    end

    initial begin : watchdog
        #(run_cycles() * 40);
        abort_run("the run timed out before all frames came out");
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin : main_seq
        int         good_before;
        int         trunc_before;
        logic [7:0] got_bytes [$];
        reset_n     = 1'b0;
        i_gmii_dv   = 1'b0;
        iv_gmii_rxd = 8'h00;
        i_gmii_er   = 1'b0;
        i_rd_en     = 1'b1;
        repeat (10) @(posedge clk_gmii_rx);
        #1;
        reset_n = 1'b1;
        @(negedge clk_gmii_rx);
        assert (!o_rx_valid && !o_rx_sof && !o_rx_eof && !o_fifo_overflow_pulse)
            else abort_run("outputs not low after reset");
        assert (ov_good_frames == 16'd0 && ov_trunc_frames == 16'd0)
            else abort_run("frame counters not zero after reset");

        // intact frames with the reader enabled
        foreach (lens_a[i]) begin
            make_frame(lens_a[i]);
            model_frame(frame_q);
            drive_frame();
        end
        while (exp_q.size() != 0) @(posedge clk_gmii_rx);
        repeat (2) @(posedge clk_gmii_rx);
        assert (int'(ov_good_frames) == exp_frames)
            else show_mismatch("ov_good_frames", int'(ov_good_frames), exp_frames);
        assert (ov_trunc_frames == 16'd0)
            else show_mismatch("ov_trunc_frames", int'(ov_trunc_frames), 0);
        assert (er_seen > 0) else abort_run("i_gmii_er was never driven high");

        // 40 bytes into a 16-word fifo with the reader stopped
        good_before  = int'(ov_good_frames);
        trunc_before = int'(ov_trunc_frames);
        #1;
        trunc_phase = 1'b1;
        i_rd_en     = 1'b0;
        make_frame(40);
        drive_frame();
        #1;
        i_rd_en = 1'b1;
        while (trunc_eofs == 0) @(posedge clk_gmii_rx);
        repeat (3) @(posedge clk_gmii_rx);
        #1;
        trunc_phase = 1'b0;
        foreach (got_q[i]) got_bytes.push_back(got_q[i][7:0]);
        assert (ovf_seen) else abort_run("no overflow pulse while the fifo was full");
        assert (is_subsequence(got_bytes, frame_q))
            else abort_run("delivered bytes are not the sent bytes in order");
        assert (got_q[0][10])
            else show_mismatch("o_rx_sof", int'(got_q[0][10]), 1);
        assert (got_q[got_q.size() - 1][8])
            else show_mismatch("o_rx_trunc", int'(got_q[got_q.size() - 1][8]), 1);
        assert (int'(ov_trunc_frames) == trunc_before + 1)
            else show_mismatch("ov_trunc_frames", int'(ov_trunc_frames), trunc_before + 1);
        assert (int'(ov_good_frames) == good_before)
            else show_mismatch("ov_good_frames", int'(ov_good_frames), good_before);

        // normal traffic again
        foreach (lens_b[i]) begin
            make_frame(lens_b[i]);
            model_frame(frame_q);
            drive_frame();
        end
        while (exp_q.size() != 0) @(posedge clk_gmii_rx);
        repeat (2) @(posedge clk_gmii_rx);
        assert (int'(ov_good_frames) == exp_frames)
            else show_mismatch("ov_good_frames", int'(ov_good_frames), exp_frames);
        assert (int'(ov_trunc_frames) == trunc_before + 1)
            else show_mismatch("ov_trunc_frames", int'(ov_trunc_frames), trunc_before + 1);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verilog/gmii_rx_top.sv
////////////////////
// gmii receive buffer top
// writer -> fifo -> frame reader
////////////////////

module gmii_rx_top
    import gmii_rx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int CNT_W      = 16
) (
    input  logic             clk_gmii_rx,
    input  logic             reset_n,
    // gmii receive
    input  logic             i_gmii_dv,
    input  logic [7:0]       iv_gmii_rxd,
    input  logic             i_gmii_er,
    // read control
    input  logic             i_rd_en,
    output logic             o_gmii_er,
    output logic             o_fifo_overflow_pulse,
    // delivered bytes
    output logic [7:0]       o_rx_data,
    output logic             o_rx_valid,
    output logic             o_rx_sof,
    output logic             o_rx_eof,
    output logic             o_rx_trunc,
    output logic [CNT_W-1:0] ov_good_frames,
    output logic [CNT_W-1:0] ov_trunc_frames
);

    logic [FIFO_WORD_W-1:0] fifo_wr_data;
    logic                   fifo_wr;
    logic                   fifo_full;
    logic [FIFO_WORD_W-1:0] fifo_rd_data;
    logic                   fifo_rd;
    logic                   fifo_empty;

    gmii_rx_writer u_writer (
        .clk_gmii_rx           (clk_gmii_rx),
        .reset_n               (reset_n),
        .i_gmii_dv             (i_gmii_dv),
        .iv_gmii_rxd           (iv_gmii_rxd),
        .i_gmii_er             (i_gmii_er),
        .i_data_full           (fifo_full),
        .o_data                (fifo_wr_data),
        .o_data_wr             (fifo_wr),
        .o_gmii_er             (o_gmii_er),
        .o_fifo_overflow_pulse (o_fifo_overflow_pulse)
    );

    gmii_rx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_gmii_rx (clk_gmii_rx),
        .reset_n     (reset_n),
        .i_wr        (fifo_wr),
        .i_wr_data   (fifo_wr_data),
        .i_rd        (fifo_rd),
        .o_rd_data   (fifo_rd_data),
        .o_full      (fifo_full),
        .o_empty     (fifo_empty)
    );

    // overflow pulse also feeds the reader's truncation tracking
    gmii_frame_reader #(
        .CNT_W (CNT_W)
    ) u_reader (
        .clk_gmii_rx     (clk_gmii_rx),
        .reset_n         (reset_n),
        .i_rd_en         (i_rd_en),
        .i_ovf           (o_fifo_overflow_pulse),
        .i_empty         (fifo_empty),
        .i_rd_data       (fifo_rd_data),
        .o_rd            (fifo_rd),
        .o_rx_data       (o_rx_data),
        .o_rx_valid      (o_rx_valid),
        .o_rx_sof        (o_rx_sof),
        .o_rx_eof        (o_rx_eof),
        .o_rx_trunc      (o_rx_trunc),
        .ov_good_frames  (ov_good_frames),
        .ov_trunc_frames (ov_trunc_frames)
    );

endmodule

//--- verilog/gmii_frame_reader.sv
////////////////////
// frame reader
// drains the fifo, restores sof/eof from the marker bit,
// counts good and truncated frames
////////////////////

module gmii_frame_reader
    import gmii_rx_pkg::*;
#(
    parameter int CNT_W = 16
) (
    input  logic                   clk_gmii_rx,
    input  logic                   reset_n,
    input  logic                   i_rd_en,
    input  logic                   i_ovf,          // writer overflow pulse
    // fifo read side
    input  logic                   i_empty,
    input  logic [FIFO_WORD_W-1:0] i_rd_data,
    output logic                   o_rd,
    // byte stream out
    output logic [7:0]             o_rx_data,
    output logic                   o_rx_valid,
    output logic                   o_rx_sof,
    output logic                   o_rx_eof,
    output logic                   o_rx_trunc,
    // statistics
    output logic [CNT_W-1:0]       ov_good_frames,
    output logic [CNT_W-1:0]       ov_trunc_frames
);

    reader_state_t state;

    logic rd_q;         // fifo word valid this cycle
    logic ovf_pend;     // data was dropped since the last frame end
    logic mark;

    ////////////////////
    // fifo read
    ////////////////////

    assign o_rd = i_rd_en && !i_empty;

    always_ff @(posedge clk_gmii_rx or negedge reset_n) begin
        if (!reset_n) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= o_rd;
        end
    end

    assign mark = i_rd_data[MARK_BIT];

    // outputs decoded from the word the fifo presents now
    assign o_rx_valid = rd_q;
    assign o_rx_data  = i_rd_data[7:0];
    assign o_rx_sof   = rd_q && mark && (state == RD_SEEK);
    assign o_rx_eof   = rd_q && mark && (state == RD_FRAME);
    assign o_rx_trunc = o_rx_eof && ovf_pend;

    ////////////////////
    // frame tracking
    ////////////////////

    always_ff @(posedge clk_gmii_rx or negedge reset_n) begin
        if (!reset_n) begin
            state <= RD_SEEK;
        end else if (rd_q && mark) begin
            // marker toggles between head and tail
            state <= (state == RD_SEEK) ? RD_FRAME : RD_SEEK;
        end
    end

    // sticky until the frame that lost bytes is closed
    always_ff @(posedge clk_gmii_rx or negedge reset_n) begin
        if (!reset_n) begin
            ovf_pend <= 1'b0;
        end else begin
            ovf_pend <= i_ovf || (ovf_pend && !o_rx_eof);
        end
    end

    ////////////////////
    // counters
    ////////////////////

    always_ff @(posedge clk_gmii_rx or negedge reset_n) begin
        if (!reset_n) begin
            ov_good_frames  <= '0;
            ov_trunc_frames <= '0;
        end else if (o_rx_eof) begin
            if (ovf_pend) begin
                ov_trunc_frames <= ov_trunc_frames + 1'b1;
            end else begin
                ov_good_frames <= ov_good_frames + 1'b1;
            end
        end
    end

    a_sof_eof_excl: assert property (
        @(posedge clk_gmii_rx) disable iff (!reset_n)
        !(o_rx_sof && o_rx_eof)
    );

endmodule

//--- verilog/gmii_rx_fifo.sv
////////////////////
// synchronous fifo for 9-bit receive words
// full and empty levels, registered read word
////////////////////

module gmii_rx_fifo
    import gmii_rx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16       // power of two
) (
    input  logic                   clk_gmii_rx,
    input  logic                   reset_n,
    // write side
    input  logic                   i_wr,
    input  logic [FIFO_WORD_W-1:0] i_wr_data,
    // read side
    input  logic                   i_rd,
    output logic [FIFO_WORD_W-1:0] o_rd_data,
    // levels
    output logic                   o_full,
    output logic                   o_empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [FIFO_WORD_W-1:0] mem [FIFO_DEPTH];

    // one extra bit to tell full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        wr_ok;
    logic        rd_ok;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // overflowing writes and underflowing reads are dropped
    assign wr_ok = i_wr && !o_full;
    assign rd_ok = i_rd && !o_empty;

    ////////////////////
    // pointers
    ////////////////////

    always_ff @(posedge clk_gmii_rx or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk_gmii_rx) begin
        if (wr_ok) begin
            mem[wr_ptr[AW-1:0]] <= i_wr_data;
        end
    end

    // word shows up the cycle after the read
    always_ff @(posedge clk_gmii_rx) begin
        if (rd_ok) begin
            o_rd_data <= mem[rd_ptr[AW-1:0]];
        end
    end

    a_full_empty_excl: assert property (
        @(posedge clk_gmii_rx) disable iff (!reset_n)
        !(o_full && o_empty)
    );

endmodule

//--- verilog/gmii_rx_writer.sv
////////////////////
// gmii receive writer
// registers the byte stream, tags head and tail bytes,
// writes fifo words and reports refused writes
////////////////////

module gmii_rx_writer
    import gmii_rx_pkg::*;
(
    input  logic                   clk_gmii_rx,
    input  logic                   reset_n,
    // gmii receive side
    input  logic                   i_gmii_dv,
    input  logic [7:0]             iv_gmii_rxd,
    input  logic                   i_gmii_er,
    // fifo write side
    input  logic                   i_data_full,
    output logic [FIFO_WORD_W-1:0] o_data,
    output logic                   o_data_wr,
    output logic                   o_gmii_er,
    output logic                   o_fifo_overflow_pulse
);

    writer_state_t state;

    logic       reg_gmii_dv;    // dv one cycle late
    logic [7:0] reg_gmii_rxd;   // byte one cycle late
    logic       start_flag;     // next word is the frame head
    logic       tail_hold;      // tail word is being offered again
    logic       last_flag;
    logic       tail_refused;

    // error bit is not part of the fifo word
    assign o_gmii_er = i_gmii_er;

    ////////////////////
    // input registers
    ////////////////////

    always_ff @(posedge clk_gmii_rx or negedge reset_n) begin
        if (!reset_n) begin
            reg_gmii_dv <= 1'b0;
        end else begin
            reg_gmii_dv <= i_gmii_dv;
        end
    end

    always_ff @(posedge clk_gmii_rx) begin
        reg_gmii_rxd <= iv_gmii_rxd;
    end

    // dv falling edge, registered byte is the last one
    assign last_flag = reg_gmii_dv && !i_gmii_dv;

    // a tail word on the bus that the fifo will not take
    assign tail_refused = o_data_wr && o_data[MARK_BIT] && i_data_full;

    ////////////////////
    // write fsm
    ////////////////////

    always_ff @(posedge clk_gmii_rx or negedge reset_n) begin
        if (!reset_n) begin
            o_data                <= '0;
            o_data_wr             <= 1'b0;
            start_flag            <= 1'b0;
            tail_hold             <= 1'b0;
            o_fifo_overflow_pulse <= 1'b0;
            state                 <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (i_gmii_dv) begin
                        // first byte goes out once it is registered
                        o_data                <= '0;
                        o_data_wr             <= 1'b0;
                        start_flag            <= 1'b1;
                        tail_hold             <= 1'b0;
                        o_fifo_overflow_pulse <= 1'b0;
                        state                 <= WR_TRANS;
                    end else begin
                        start_flag <= 1'b0;
                        tail_hold  <= tail_refused;
                        if (tail_refused) begin
                            // keep offering the same tail word
                            o_data_wr             <= 1'b1;
                            o_fifo_overflow_pulse <= !tail_hold;
                        end else begin
                            o_data                <= '0;
                            o_data_wr             <= 1'b0;
                            o_fifo_overflow_pulse <= 1'b0;
                        end
                    end
                end

                WR_TRANS: begin
                    start_flag       <= 1'b0;   // head flag lives one cycle
                    tail_hold        <= 1'b0;
                    o_data[7:0]      <= reg_gmii_rxd;
                    o_data[MARK_BIT] <= start_flag || last_flag;
                    if (!i_data_full) begin
                        o_data_wr             <= reg_gmii_dv;
                        o_fifo_overflow_pulse <= 1'b0;
                        state                 <= last_flag ? WR_IDLE : WR_TRANS;
                    end else begin
                        // fifo refuses, report once and ride out the frame
                        o_data_wr             <= 1'b1;
                        o_fifo_overflow_pulse <= 1'b1;
                        tail_hold             <= last_flag;  // refusal already reported
                        state                 <= last_flag ? WR_IDLE : WR_FULL_ERR;
                    end
                end

                WR_FULL_ERR: begin
                    start_flag            <= 1'b0;
                    tail_hold             <= 1'b0;
                    o_fifo_overflow_pulse <= 1'b0;
                    o_data_wr             <= 1'b1;
                    // marker goes on the word written as dv drops
                    o_data                <= {!i_gmii_dv, reg_gmii_rxd};
                    state                 <= i_gmii_dv ? WR_FULL_ERR : WR_IDLE;
                end

                default: begin
                    o_data                <= '0;
                    o_data_wr             <= 1'b0;
                    start_flag            <= 1'b0;
                    tail_hold             <= 1'b0;
                    o_fifo_overflow_pulse <= 1'b0;
                    state                 <= WR_IDLE;
                end
            endcase
        end
    end

    // a tail retry reports its refusal only once
    a_no_double_pulse_idle: assert property (
        @(posedge clk_gmii_rx) disable iff (!reset_n)
        (state == WR_IDLE && o_fifo_overflow_pulse)
            |=> !(state == WR_IDLE && o_fifo_overflow_pulse)
    );

endmodule

//--- verilog/gmii_rx_pkg.sv
////////////////////
// shared constants for the gmii receive buffer
// fifo word layout and fsm state encodings
////////////////////

package gmii_rx_pkg;

    ////////////////////
    // fifo word layout
    ////////////////////

    // 8 data bits plus one frame marker
    localparam int FIFO_WORD_W = 9;

    // marker set on first and last byte of a frame
    localparam int MARK_BIT    = 8;

    ////////////////////
    // fsm states
    ////////////////////

    typedef enum logic [1:0] {
        WR_IDLE     = 2'b00,    // waiting for dv
        WR_TRANS    = 2'b01,    // frame in flight
        WR_FULL_ERR = 2'b10     // fifo refused data, wait for end of frame
    } writer_state_t;

    typedef enum logic {
        RD_SEEK  = 1'b0,        // looking for a head marker
        RD_FRAME = 1'b1         // between head and tail
    } reader_state_t;

endpackage
